// File: run_sim.sh
#!/usr/bin/env bash
# Build the SDMAC testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module sdmac_tb \
    -o sdmac_sim > build.log 2>&1 && ./obj_dir/sdmac_sim > sim.log 2>&1
grep -q "Simulation passed" sim.log 2>/dev/null && echo "PASS" && exit 0 || echo "FAIL" && exit 1

// File: sdmac_assert.sv
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module sdmac_assert (
    input logic             CLK,
    input logic             _AS,
    input logic             sterm,
    input logic             irq,
    input sdmac_pkg::ctrl_s ctrl,
    input sdmac_pkg::xfer_s xfer
);

    logic inten;
    logic active;
    logic done;

    assign inten  = ctrl.cntr[`CNTR_INTEN];
    assign active = xfer.active;
    assign done   = xfer.done;

    // One termination pulse per access
    a_sterm_single: assert property (@(posedge CLK) disable iff (_AS)
        sterm |=> !sterm)
        else $error("sterm high for two cycles in a row");

    // irq is registered, so it follows INTEN one cycle late
    a_irq_inten: assert property (@(posedge CLK) disable iff (_AS)
        irq |-> $past(inten))
        else $error("irq high while INTEN was low");

    a_done_in_run: assert property (@(posedge CLK) disable iff (_AS)
        done |-> $past(active))
        else $error("transfer done outside of a running transfer");

endmodule

bind sdmac_top sdmac_assert u_assert (
    .CLK   (CLK),
    ._AS   (_AS),
    .sterm (sterm),
    .irq   (irq),
    .ctrl  (ctrl),
    .xfer  (xfer)
);

// File: sdmac_macros.svh
`ifndef SDMAC_MACROS_SVH
`define SDMAC_MACROS_SVH

// Bus and register widths
`define ADDR_W          8
`define DATA_W          32
`define WTC_W           24
`define CNTR_W          6
`define ISTR_W          9
`define DAWR_W          2

// Register offsets within the SDMAC window
`define REG_DAWR        8'h00   // Write only
`define REG_WTC         8'h04
`define REG_CNTR        8'h08
`define REG_ST_DMA      8'h10   // Strobe
`define REG_FLUSH       8'h14   // Strobe
`define REG_CINT        8'h18   // Strobe
`define REG_ISTR        8'h1C   // Read only
`define REG_SP_DMA      8'h3C   // Strobe

// CNTR bits
`define CNTR_INTEN      2
`define CNTR_DDIR       1

// ISTR bits, the rest read zero
`define ISTR_INT_F      8       // Any interrupt pending
`define ISTR_INTS       4       // SCSI chip interrupt
`define ISTR_E_INT      3       // End of transfer
`define ISTR_DMA_ACT    1

`endif

// File: sdmac_pkg.sv
`include "sdmac_macros.svh"

package sdmac_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;     // CPU register offset
    typedef logic [`DATA_W-1:0] data_t;     // CPU data word
    typedef logic [`WTC_W-1:0]  wtc_t;      // Word transfer count
    typedef logic [`CNTR_W-1:0] cntr_t;     // Control register
    typedef logic [`ISTR_W-1:0] istr_t;     // Interrupt status register

    // Which register a read returns
    typedef enum logic [1:0] {
        RD_NONE,
        RD_WTC,
        RD_CNTR,
        RD_ISTR
    } rd_src_e;

    typedef enum logic {
        XF_IDLE,
        XF_RUN
    } xfer_state_e;

    // Register block results, all one cycle after the access
    typedef struct packed {
        logic    acc;       // Any access
        rd_src_e rd_src;
        wtc_t    wtc;
        cntr_t   cntr;
        logic    st_dma;
        logic    sp_dma;
        logic    flush;
        logic    clr_int;
    } ctrl_s;

    // Transfer counter results
    typedef struct packed {
        logic active;
        wtc_t count;        // Words still to go
        logic done;         // Count hit zero
    } xfer_s;

endpackage

// File: sdmac_regs.sv
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module sdmac_regs (
    input  logic                CLK,
    input  logic                _AS,
    input  logic                sel,
    input  logic                wr,
    input  sdmac_pkg::addr_t    addr,
    input  sdmac_pkg::data_t    wdata,
    output sdmac_pkg::ctrl_s    ctrl,
    output logic [`DAWR_W-1:0]  dawr
);

    logic hit_dawr;
    logic hit_wtc;
    logic hit_cntr;
    logic hit_st_dma;
    logic hit_flush;
    logic hit_cint;
    logic hit_istr;
    logic hit_sp_dma;

    sdmac_pkg::rd_src_e rd_src_d;
    sdmac_pkg::rd_src_e rd_src_q;
    sdmac_pkg::wtc_t    wtc_q;
    sdmac_pkg::cntr_t   cntr_q;
    logic [`DAWR_W-1:0] dawr_q;
    logic               acc_q;
    logic               st_dma_q;
    logic               sp_dma_q;
    logic               flush_q;
    logic               clr_int_q;

    // One decode shared by reads, writes and strobes
    always_comb begin
        hit_dawr   = 1'b0;
        hit_wtc    = 1'b0;
        hit_cntr   = 1'b0;
        hit_st_dma = 1'b0;
        hit_flush  = 1'b0;
        hit_cint   = 1'b0;
        hit_istr   = 1'b0;
        hit_sp_dma = 1'b0;
        case (addr)
            `REG_DAWR:   hit_dawr   = 1'b1;
            `REG_WTC:    hit_wtc    = 1'b1;
            `REG_CNTR:   hit_cntr   = 1'b1;
            `REG_ST_DMA: hit_st_dma = 1'b1;
            `REG_FLUSH:  hit_flush  = 1'b1;
            `REG_CINT:   hit_cint   = 1'b1;
            `REG_ISTR:   hit_istr   = 1'b1;
            `REG_SP_DMA: hit_sp_dma = 1'b1;
            default: ;
        endcase
    end

    // DAWR and strobes have nothing to return
    always_comb begin
        rd_src_d = sdmac_pkg::RD_NONE;
        if (sel && !wr) begin
            if (hit_wtc)       rd_src_d = sdmac_pkg::RD_WTC;
            else if (hit_cntr) rd_src_d = sdmac_pkg::RD_CNTR;
            else if (hit_istr) rd_src_d = sdmac_pkg::RD_ISTR;
        end
    end

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            acc_q     <= 1'b0;
            rd_src_q  <= sdmac_pkg::RD_NONE;
            st_dma_q  <= 1'b0;
            sp_dma_q  <= 1'b0;
            flush_q   <= 1'b0;
            clr_int_q <= 1'b0;
            wtc_q     <= '0;
            cntr_q    <= '0;
            dawr_q    <= '0;
        end else begin
            acc_q     <= sel;
            rd_src_q  <= rd_src_d;
            st_dma_q  <= sel && hit_st_dma;     // Read or write alike
            sp_dma_q  <= sel && hit_sp_dma;
            flush_q   <= sel && hit_flush;
            clr_int_q <= sel && hit_cint;
            if (sel && wr) begin
                if (hit_dawr) dawr_q <= wdata[`DAWR_W-1:0];
                if (hit_wtc)  wtc_q  <= wdata[`WTC_W-1:0];
                if (hit_cntr) cntr_q <= wdata[`CNTR_W-1:0];
            end
        end
    end

    always_comb begin
        ctrl.acc     = acc_q;
        ctrl.rd_src  = rd_src_q;
        ctrl.wtc     = wtc_q;
        ctrl.cntr    = cntr_q;
        ctrl.st_dma  = st_dma_q;
        ctrl.sp_dma  = sp_dma_q;
        ctrl.flush   = flush_q;
        ctrl.clr_int = clr_int_q;
    end

    assign dawr = dawr_q;

endmodule

// File: sdmac_status.sv
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module sdmac_status (
    input  logic             CLK,
    input  logic             _AS,
    input  sdmac_pkg::ctrl_s ctrl,
    input  sdmac_pkg::xfer_s xfer,
    input  logic             scsi_int,
    output sdmac_pkg::data_t rdata,
    output logic             sterm,
    output logic             irq,
    output logic             dma_dir
);

    logic               e_int_q;
    logic               ints_q;
    logic               irq_q;
    logic               sterm_q;
    sdmac_pkg::data_t   rdata_q;
    sdmac_pkg::data_t   rd_word;
    sdmac_pkg::istr_t   istr;
    sdmac_pkg::wtc_t    wtc_live;

    // Sticky event bits, set wins over clear
    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            e_int_q <= 1'b0;
            ints_q  <= 1'b0;
        end else begin
            if (xfer.done)
                e_int_q <= 1'b1;
            else if (ctrl.clr_int)
                e_int_q <= 1'b0;

            if (scsi_int)
                ints_q <= 1'b1;
            else if (ctrl.clr_int)
                ints_q <= 1'b0;
        end
    end

    always_comb begin
        istr                = '0;
        istr[`ISTR_INT_F]   = e_int_q | ints_q;
        istr[`ISTR_INTS]    = ints_q;
        istr[`ISTR_E_INT]   = e_int_q;
        istr[`ISTR_DMA_ACT] = xfer.active;
    end

    // Running count during a transfer, programmed value otherwise
    assign wtc_live = xfer.active ? xfer.count : ctrl.wtc;

    always_comb begin
        case (ctrl.rd_src)
            sdmac_pkg::RD_WTC:  rd_word = {{(`DATA_W - `WTC_W){1'b0}}, wtc_live};
            sdmac_pkg::RD_CNTR: rd_word = {{(`DATA_W - `CNTR_W){1'b0}}, ctrl.cntr};
            sdmac_pkg::RD_ISTR: rd_word = {{(`DATA_W - `ISTR_W){1'b0}}, istr};
            default:            rd_word = '0;
        endcase
    end

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            rdata_q <= '0;
            sterm_q <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            sterm_q <= ctrl.acc;                // Terminate every access
            if (ctrl.acc)
                rdata_q <= rd_word;
            irq_q <= istr[`ISTR_INT_F] & ctrl.cntr[`CNTR_INTEN];
        end
    end

    assign rdata   = rdata_q;
    assign sterm   = sterm_q;
    assign irq     = irq_q;
    assign dma_dir = ctrl.cntr[`CNTR_DDIR];     // 1 = write to memory

endmodule

// File: sdmac_tb.sv
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module sdmac_tb;

    typedef struct packed {
        logic             rd;
        sdmac_pkg::data_t exp;
        logic [31:0]      cyc;    // Cycle in which sel was driven
    } pend_s;

    logic               CLK;
    logic               _AS;
    logic               sel;
    logic               wr;
    sdmac_pkg::addr_t   addr;
    sdmac_pkg::data_t   wdata;
    logic               dreq;
    logic               scsi_int;
    sdmac_pkg::data_t   rdata;
    logic               sterm;
    logic               irq;
    logic               dack;
    logic               dma_dir;
    logic [`DAWR_W-1:0] dawr;

    logic [31:0]        lfsr;
    logic [31:0]        cyc;
    pend_s              pend[$];
    string              pend_name[$];

    // Shadow model of the register and transfer state
    sdmac_pkg::wtc_t    m_wtc;
    sdmac_pkg::wtc_t    m_count;
    sdmac_pkg::cntr_t   m_cntr;
    logic [`DAWR_W-1:0] m_dawr;
    logic               m_active;
    logic               m_e_int;
    logic               m_ints;
    logic               m_scsi;

    sdmac_top dut (
        .CLK(CLK), ._AS(_AS), .sel(sel), .wr(wr), .addr(addr), .wdata(wdata),
        .dreq(dreq), .scsi_int(scsi_int), .rdata(rdata), .sterm(sterm),
        .irq(irq), .dack(dack), .dma_dir(dma_dir), .dawr(dawr)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) cyc <= cyc + 32'd1;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_value(input string name, input sdmac_pkg::data_t exp,
                               input sdmac_pkg::data_t act);
        assert (act === exp)
        else stop_on_error($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_true(input logic cond, input string why);
        assert (cond) else stop_on_error(why);
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic is_mapped(input sdmac_pkg::addr_t a);
        case (a)
            `REG_DAWR, `REG_WTC, `REG_CNTR, `REG_ST_DMA,
            `REG_FLUSH, `REG_CINT, `REG_ISTR, `REG_SP_DMA: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic sdmac_pkg::addr_t unmapped_addr();
        sdmac_pkg::addr_t a;
        a = sdmac_pkg::addr_t'(next_bits(8));
        if (is_mapped(a))
            a = a ^ 8'h02;              // Mapped offsets all end in 00
        return a;
    endfunction

    // Expected read data from the register map rules
    function automatic sdmac_pkg::data_t exp_read(input sdmac_pkg::addr_t a);
        sdmac_pkg::istr_t istr;
        istr                = '0;
        istr[`ISTR_INT_F]   = m_e_int | m_ints;
        istr[`ISTR_INTS]    = m_ints;
        istr[`ISTR_E_INT]   = m_e_int;
        istr[`ISTR_DMA_ACT] = m_active;
        case (a)
            `REG_WTC:  return sdmac_pkg::data_t'(m_active ? m_count : m_wtc);
            `REG_CNTR: return sdmac_pkg::data_t'(m_cntr);
            `REG_ISTR: return sdmac_pkg::data_t'(istr);
            default:   return '0;
        endcase
    endfunction

    function automatic void apply_access(input logic w, input sdmac_pkg::addr_t a,
                                         input sdmac_pkg::data_t d);
        if (w && a == `REG_DAWR) m_dawr = d[`DAWR_W-1:0];
        if (w && a == `REG_WTC)  m_wtc  = d[`WTC_W-1:0];
        if (w && a == `REG_CNTR) m_cntr = d[`CNTR_W-1:0];
        if (a == `REG_ST_DMA && !m_active && m_wtc != '0) begin
            m_active = 1'b1;
            m_count  = m_wtc;
        end
        if (a == `REG_SP_DMA || a == `REG_FLUSH)
            m_active = 1'b0;
        if (a == `REG_CINT) begin
            m_e_int = 1'b0;
            m_ints  = m_scsi;           // Still pending sets again
        end
    endfunction

    // One-cycle access followed by one idle cycle
    task automatic bus_access(input logic w, input sdmac_pkg::addr_t a,
                              input sdmac_pkg::data_t d, input string name);
        pend_s p;
        p.rd  = !w;
        p.exp = exp_read(a);
        p.cyc = cyc;
        pend.push_back(p);
        pend_name.push_back(name);
        apply_access(w, a, d);
        sel   = 1'b1;
        wr    = w;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        sel   = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        @(negedge CLK);
    endtask

    task automatic word_strobe(input logic d);
        logic take;
        take = d && m_active;
        if (take) begin
            m_count = m_count - 24'd1;
            if (m_count == '0) begin
                m_active = 1'b0;
                m_e_int  = 1'b1;
            end
        end
        dreq = d;
        @(negedge CLK);
        dreq = 1'b0;
        check_value("dack", take, dack);
    endtask

    task automatic set_scsi(input logic v);
        scsi_int = v;
        m_scsi   = v;
        if (v)
            m_ints = 1'b1;
        @(negedge CLK);
    endtask

    task automatic check_irq(input string name);
        repeat (2) @(negedge CLK);
        check_value(name, (m_e_int | m_ints) & m_cntr[`CNTR_INTEN], irq);
    endtask

    // Random word strobes until the model count runs out
    task automatic run_words();
        for (int i = 0; i < 400 && m_active; i++) begin
            word_strobe(next_bits(1) == 32'd1);
            if (next_bits(2) == 32'd0) begin
                bus_access(1'b0, `REG_WTC, '0, "wtc during transfer");
                bus_access(1'b0, `REG_ISTR, '0, "istr during transfer");
            end
        end
        check_true(!m_active, "transfer did not finish within 400 word strobes");
    endtask

    // Comparing process, one entry per sterm pulse
    always @(negedge CLK) begin
        pend_s p;
        string nm;
        if (!_AS) begin
            if (sterm) begin
                check_true(pend.size() != 0, "sterm pulse without a bus access");
                p  = pend.pop_front();
                nm = pend_name.pop_front();
                check_value({nm, " sterm cycle"}, p.cyc + 32'd2, cyc);
                if (p.rd)
                    check_value(nm, p.exp, rdata);
            end else if (pend.size() != 0) begin
                check_true(cyc <= pend[0].cyc + 32'd10, "timeout waiting for sterm");
            end
        end
    end

    initial begin : stimulus
        sdmac_pkg::addr_t a;
        lfsr = 32'h08e9b034;
        cyc = '0;
        {m_wtc, m_count, m_cntr, m_dawr} = '0;
        {m_active, m_e_int, m_ints, m_scsi} = '0;
        _AS = 1'b1;
        {sel, wr, dreq, scsi_int} = '0;
        addr = '0;
        wdata = '0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        _AS = 1'b0;
        @(negedge CLK);

        for (int i = 0; i < 6; i++) begin
            bus_access(1'b1, `REG_WTC, next_bits(32), "wtc write");
            bus_access(1'b0, `REG_WTC, '0, "wtc readback");
            bus_access(1'b1, `REG_CNTR, next_bits(32), "cntr write");
            bus_access(1'b0, `REG_CNTR, '0, "cntr readback");
            check_value("dma_dir", m_cntr[`CNTR_DDIR], dma_dir);
            bus_access(1'b1, `REG_DAWR, next_bits(32), "dawr write");
            check_value("dawr", m_dawr, dawr);
            bus_access(1'b0, `REG_DAWR, '0, "dawr read");
            bus_access(1'b1, `REG_ISTR, next_bits(32), "istr write");
            bus_access(1'b0, `REG_ISTR, '0, "istr read");
            a = unmapped_addr();
            bus_access(1'b1, a, next_bits(32), "undecoded write");
            bus_access(1'b0, a, '0, "undecoded read");
        end

        // Transfers, irq enabled for the first two
        bus_access(1'b1, `REG_CNTR, 32'h4, "cntr inten");
        for (int t = 0; t < 3; t++) begin
            bus_access(1'b1, `REG_WTC, next_bits(3) + 32'd1, "wtc load");
            bus_access(next_bits(1) == 32'd1, `REG_ST_DMA, next_bits(32), "st_dma");
            bus_access(1'b0, `REG_ISTR, '0, "istr started");
            run_words();
            bus_access(1'b0, `REG_ISTR, '0, "istr end of transfer");
            bus_access(1'b0, `REG_WTC, '0, "wtc after end");
            check_irq("irq at end of transfer");
            bus_access(next_bits(1) == 32'd1, `REG_CINT, next_bits(32), "cint");
            bus_access(1'b0, `REG_ISTR, '0, "istr after cint");
            check_irq("irq after cint");
            if (t == 1)
                bus_access(1'b1, `REG_CNTR, 32'h0, "cntr inten off");
        end

        // Aborts and a zero count start
        bus_access(1'b1, `REG_WTC, 32'd40, "wtc for abort");
        bus_access(1'b0, `REG_ST_DMA, '0, "st_dma by read");
        repeat (5) word_strobe(next_bits(1) == 32'd1);
        bus_access(1'b0, `REG_WTC, '0, "wtc before sp_dma");
        bus_access(next_bits(1) == 32'd1, `REG_SP_DMA, '0, "sp_dma");
        bus_access(1'b0, `REG_ISTR, '0, "istr after sp_dma");
        word_strobe(1'b1);
        bus_access(1'b1, `REG_ST_DMA, '0, "st_dma by write");
        repeat (3) word_strobe(1'b1);
        bus_access(1'b0, `REG_FLUSH, '0, "flush");
        bus_access(1'b0, `REG_ISTR, '0, "istr after flush");
        bus_access(1'b0, `REG_WTC, '0, "wtc after flush");
        bus_access(1'b1, `REG_WTC, '0, "wtc zero");
        bus_access(1'b1, `REG_ST_DMA, '0, "st_dma zero count");
        bus_access(1'b0, `REG_ISTR, '0, "istr zero count");
        word_strobe(1'b1);

        // SCSI chip interrupt
        bus_access(1'b1, `REG_CNTR, 32'h4, "cntr inten on");
        set_scsi(1'b1);
        bus_access(1'b0, `REG_ISTR, '0, "ints set");
        check_irq("irq from scsi");
        bus_access(1'b1, `REG_CINT, '0, "cint while scsi high");
        bus_access(1'b0, `REG_ISTR, '0, "ints held");
        set_scsi(1'b0);
        bus_access(1'b0, `REG_ISTR, '0, "ints sticky");
        bus_access(1'b0, `REG_CINT, '0, "cint after scsi low");
        bus_access(1'b0, `REG_ISTR, '0, "ints cleared");
        check_irq("irq after scsi clear");

        // Random mix of accesses and word strobes
        for (int i = 0; i < 24; i++) begin
            case (next_bits(3))
                32'd0:   a = `REG_DAWR;
                32'd1:   a = `REG_WTC;
                32'd2:   a = `REG_CNTR;
                32'd3:   a = `REG_ST_DMA;
                32'd4:   a = `REG_FLUSH;
                32'd5:   a = `REG_CINT;
                32'd6:   a = `REG_ISTR;
                default: a = (next_bits(1) == 32'd1) ? `REG_SP_DMA : unmapped_addr();
            endcase
            bus_access(next_bits(1) == 32'd1, a, next_bits(32), "random access");
            if (next_bits(1) == 32'd1)
                word_strobe(next_bits(1) == 32'd1);
        end

        for (int i = 0; i < 10 && pend.size() != 0; i++)
            @(negedge CLK);
        check_true(pend.size() == 0, "timeout draining pending accesses");
        repeat (5) @(negedge CLK);       // Idle bus, no sterm expected
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: sdmac_top.sv
`timescale 1ns/10ps
`include "sdmac_macros.svh"

module sdmac_top (
    input  logic                CLK,
    input  logic                _AS,
    input  logic                sel,
    input  logic                wr,
    input  sdmac_pkg::addr_t    addr,
    input  sdmac_pkg::data_t    wdata,
    input  logic                dreq,
    input  logic                scsi_int,
    output sdmac_pkg::data_t    rdata,
    output logic                sterm,
    output logic                irq,
    output logic                dack,
    output logic                dma_dir,
    output logic [`DAWR_W-1:0]  dawr
);

    sdmac_pkg::ctrl_s ctrl;     // Register block to counter and status
    sdmac_pkg::xfer_s xfer;     // Counter to status

    sdmac_regs u_regs (
        .CLK   (CLK),
        ._AS   (_AS),
        .sel   (sel),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .ctrl  (ctrl),
        .dawr  (dawr)
    );

    sdmac_xfer u_xfer (
        .CLK  (CLK),
        ._AS  (_AS),
        .ctrl (ctrl),
        .dreq (dreq),
        .xfer (xfer),
        .dack (dack)
    );

    sdmac_status u_status (
        .CLK      (CLK),
        ._AS      (_AS),
        .ctrl     (ctrl),
        .xfer     (xfer),
        .scsi_int (scsi_int),
        .rdata    (rdata),
        .sterm    (sterm),
        .irq      (irq),
        .dma_dir  (dma_dir)
    );

endmodule

// File: sdmac_xfer.sv
`timescale 1ns/10ps

module sdmac_xfer (
    input  logic             CLK,
    input  logic             _AS,
    input  sdmac_pkg::ctrl_s ctrl,
    input  logic             dreq,
    output sdmac_pkg::xfer_s xfer,
    output logic             dack
);

    sdmac_pkg::xfer_state_e state_q;
    sdmac_pkg::wtc_t        count_q;
    logic                   done_q;
    logic                   dack_q;
    logic                   abort;
    logic                   take;
    logic                   last;

    assign abort = ctrl.sp_dma | ctrl.flush;
    // Word strobe counted this cycle
    assign take  = (state_q == sdmac_pkg::XF_RUN) && dreq && !abort;
    assign last  = (count_q == sdmac_pkg::wtc_t'(1));

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            state_q <= sdmac_pkg::XF_IDLE;
            count_q <= '0;
            done_q  <= 1'b0;
            dack_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            dack_q <= take;
            case (state_q)
                sdmac_pkg::XF_IDLE: begin
                    // Zero count means nothing to move
                    if (ctrl.st_dma && (ctrl.wtc != '0)) begin
                        state_q <= sdmac_pkg::XF_RUN;
                        count_q <= ctrl.wtc;
                    end
                end
                sdmac_pkg::XF_RUN: begin
                    if (abort) begin
                        state_q <= sdmac_pkg::XF_IDLE;  // Stop, count kept
                    end else if (take) begin
                        count_q <= count_q - 1'b1;
                        if (last) begin
                            done_q  <= 1'b1;
                            state_q <= sdmac_pkg::XF_IDLE;
                        end
                    end
                end
                default: state_q <= sdmac_pkg::XF_IDLE;
            endcase
        end
    end

    always_comb begin
        xfer.active = (state_q == sdmac_pkg::XF_RUN);
        xfer.count  = count_q;
        xfer.done   = done_q;
    end

    assign dack = dack_q;

endmodule

// File: sources.f
+incdir+.
sdmac_pkg.sv
sdmac_regs.sv
sdmac_xfer.sv
sdmac_status.sv
sdmac_top.sv
sdmac_assert.sv
sdmac_tb.sv
